// File: Makefile
# Verilator build and run for the platform shim testbench

TOP := tb_platform_shim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f compile.f -Mdir obj_dir -o $(TOP)

# The run fails unless the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: afu/afu_csr_block.sv
// Minimal AFU CSR set; reads always answer one cycle later and unmapped reads return 0
`timescale 1ns/1ns

module afu_csr_block
#(
    parameter afu_shim_pkg::t_mmio_data AFU_ID_LO = 64'h0,
    parameter afu_shim_pkg::t_mmio_data AFU_ID_HI = 64'h0
)
(
    input  logic ccip_to_afu,
    input  logic afu_reset,

    // Requests from the shim
    input  logic rx_rd,
    input  logic rx_wr,
    input  afu_shim_pkg::t_mmio_addr rx_addr,
    input  afu_shim_pkg::t_mmio_tid rx_tid,
    input  afu_shim_pkg::t_mmio_data rx_data,
    input  afu_shim_pkg::t_power_state afu_power_state,

    // Read responses back to the shim
    output logic tx_rsp_valid,
    output afu_shim_pkg::t_mmio_tid tx_rsp_tid,
    output afu_shim_pkg::t_mmio_data tx_rsp_data
);

    import afu_shim_pkg::*;

    // ======================================================================
    // CSR storage
    // ======================================================================

    t_mmio_data scratch;
    logic [15:0] wr_count;
    t_power_state power_q;
    t_mmio_data rd_data;

    // Scratch and the write counter are the only state a reset must clear
    always_ff @(posedge ccip_to_afu)
    begin
        if (afu_reset)
        begin
            scratch <= '0;
            wr_count <= '0;
        end
        else if (rx_wr)
        begin
            // Every write counts, mapped or not, and the counter wraps
            wr_count <= wr_count + 16'd1;

            if (rx_addr == CSR_SCRATCH)
            begin
                scratch <= rx_data;
            end
        end
    end

    // The power state is sampled every cycle for readback
    always_ff @(posedge ccip_to_afu)
    begin
        power_q <= afu_power_state;
    end

    // ======================================================================
    // Read decode
    // ======================================================================

    always_comb
    begin
        case (rx_addr)
            CSR_DFH: rd_data = AFU_DFH_VALUE;
            CSR_AFU_ID_LO: rd_data = AFU_ID_LO;
            CSR_AFU_ID_HI: rd_data = AFU_ID_HI;
            CSR_SCRATCH: rd_data = scratch;
            // Narrow registers come back zero-extended
            CSR_POWER: rd_data = {62'b0, power_q};
            CSR_WR_COUNT: rd_data = {48'b0, wr_count};
            default: rd_data = '0;
        endcase
    end

    // ======================================================================
    // Response register
    // ======================================================================

    // Each read gets exactly one response on the following cycle
    always_ff @(posedge ccip_to_afu)
    begin
        if (afu_reset)
        begin
            tx_rsp_valid <= 1'b0;
        end
        else
        begin
            tx_rsp_valid <= rx_rd;
        end
    end

    // The tid is echoed so the host can match responses to reads
    always_ff @(posedge ccip_to_afu)
    begin
        tx_rsp_tid <= rx_tid;
        tx_rsp_data <= rd_data;
    end

    // ======================================================================
    // Checks
    // ======================================================================

    // A response may only follow a read seen on the previous cycle
    a_rsp_after_rd: assert property (@(posedge ccip_to_afu) disable iff (afu_reset)
        $rose(tx_rsp_valid) |-> $past(rx_rd));

endmodule

// File: common/afu_shim_pkg.sv
// Shared MMIO types and CSR map; addresses count 4-byte words and every CSR is 64 bits wide
package afu_shim_pkg;

    // ======================================================================
    // Basic MMIO field types
    // ======================================================================

    // Word address as it arrives from the host channel, in 4-byte units
    typedef logic [15:0] t_mmio_addr;

    // Full 64-bit MMIO data path, used for both write data and read data
    typedef logic [63:0] t_mmio_data;

    // Transaction ID, echoed unchanged in the matching read response
    typedef logic [8:0] t_mmio_tid;

    // Platform power state as driven by the FIU
    typedef logic [1:0] t_power_state;

    // ======================================================================
    // Stage payloads
    // ======================================================================

    // Request record carried from the host channel to the AFU.
    // The power state rides along so that it sees the same pipeline delay
    typedef struct packed
    {
        logic rd;
        logic wr;
        t_mmio_addr addr;
        t_mmio_tid tid;
        t_mmio_data data;
        t_power_state power_state;
    } t_mmio_req;

    // Response record carried from the AFU back to the host channel
    typedef struct packed
    {
        logic valid;
        t_mmio_tid tid;
        t_mmio_data data;
    } t_mmio_rsp;

    // ======================================================================
    // CSR address map
    // ======================================================================

    // Each CSR occupies two 32-bit words, so the 64-bit registers sit on
    // even word addresses
    localparam t_mmio_addr CSR_DFH = 16'h0000;
    localparam t_mmio_addr CSR_AFU_ID_LO = 16'h0002;
    localparam t_mmio_addr CSR_AFU_ID_HI = 16'h0004;
    localparam t_mmio_addr CSR_SCRATCH = 16'h0006;
    localparam t_mmio_addr CSR_POWER = 16'h0008;
    localparam t_mmio_addr CSR_WR_COUNT = 16'h000A;

    // Device feature header.
    // Bits [63:60] hold the feature type, where 1 means AFU.
    // Bit 40 is end-of-list, and the next-DFH offset stays zero
    localparam t_mmio_data AFU_DFH_VALUE = 64'h1000_0100_0000_0000;

endpackage

// File: compile.f
common/afu_shim_pkg.sv
src/ccip_timing_stages.sv
host_chan/host_chan_as_ccip.sv
afu/afu_csr_block.sv
src/platform_shim_afu_top.sv
+incdir+tb
tb/tb_platform_shim.sv

// File: host_chan/host_chan_as_ccip.sv
// Host-channel MMIO to CCI-P strobes; no back-pressure, only one request strobe per cycle
`timescale 1ns/1ns

module host_chan_as_ccip
#(
    parameter int TIMING_STAGES = 2
)
(
    input  logic ccip_to_afu,
    input  logic reset,

    // Raw host-channel MMIO side
    input  logic mmio_rd_req,
    input  logic mmio_wr_req,
    input  afu_shim_pkg::t_mmio_addr mmio_addr,
    input  afu_shim_pkg::t_mmio_tid mmio_tid,
    input  afu_shim_pkg::t_mmio_data mmio_wr_data,
    input  afu_shim_pkg::t_power_state fiu_power_state,
    output logic mmio_rsp_valid,
    output afu_shim_pkg::t_mmio_tid mmio_rsp_tid,
    output afu_shim_pkg::t_mmio_data mmio_rsp_data,

    // AFU side
    output logic afu_reset,
    output logic rx_rd,
    output logic rx_wr,
    output afu_shim_pkg::t_mmio_addr rx_addr,
    output afu_shim_pkg::t_mmio_tid rx_tid,
    output afu_shim_pkg::t_mmio_data rx_data,
    output afu_shim_pkg::t_power_state afu_power_state,
    input  logic tx_rsp_valid,
    input  afu_shim_pkg::t_mmio_tid tx_rsp_tid,
    input  afu_shim_pkg::t_mmio_data tx_rsp_data
);

    import afu_shim_pkg::*;

    // ======================================================================
    // Reset timing stage
    // ======================================================================

    // The AFU sees reset one cycle late, which gives the reset net its own
    // register close to the AFU
    always_ff @(posedge ccip_to_afu)
    begin
        afu_reset <= reset;
    end

    // ======================================================================
    // Request path
    // ======================================================================

    logic req_valid_q;
    t_mmio_req req_q;
    logic req_stage_valid;
    t_mmio_req req_stage;

    // Input register. The valid bit marks a cycle that carries a read or a write
    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            req_valid_q <= 1'b0;
        end
        else
        begin
            req_valid_q <= mmio_rd_req | mmio_wr_req;
        end
    end

    // The record is loaded every cycle so the power state keeps flowing
    always_ff @(posedge ccip_to_afu)
    begin
        req_q.rd <= mmio_rd_req;
        req_q.wr <= mmio_wr_req;
        req_q.addr <= mmio_addr;
        req_q.tid <= mmio_tid;
        req_q.data <= mmio_wr_data;
        req_q.power_state <= fiu_power_state;
    end

    ccip_timing_stages
    #(
        .T(t_mmio_req),
        .STAGES(TIMING_STAGES)
    )
    req_stages
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(reset),
        .in_valid(req_valid_q),
        .in_data(req_q),
        .out_valid(req_stage_valid),
        .out_data(req_stage)
    );

    // Strobes are qualified by the stage valid so stale payload never fires
    assign rx_rd = req_stage_valid & req_stage.rd;
    assign rx_wr = req_stage_valid & req_stage.wr;
    assign rx_addr = req_stage.addr;
    assign rx_tid = req_stage.tid;
    assign rx_data = req_stage.data;
    assign afu_power_state = req_stage.power_state;

    // ======================================================================
    // Response path
    // ======================================================================

    t_mmio_rsp rsp_in;
    logic rsp_stage_valid;
    t_mmio_rsp rsp_stage;

    assign rsp_in.valid = tx_rsp_valid;
    assign rsp_in.tid = tx_rsp_tid;
    assign rsp_in.data = tx_rsp_data;

    ccip_timing_stages
    #(
        .T(t_mmio_rsp),
        .STAGES(TIMING_STAGES)
    )
    rsp_stages
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(reset),
        .in_valid(tx_rsp_valid),
        .in_data(rsp_in),
        .out_valid(rsp_stage_valid),
        .out_data(rsp_stage)
    );

    // Output register toward the host
    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            mmio_rsp_valid <= 1'b0;
        end
        else
        begin
            mmio_rsp_valid <= rsp_stage_valid & rsp_stage.valid;
        end
    end

    always_ff @(posedge ccip_to_afu)
    begin
        mmio_rsp_tid <= rsp_stage.tid;
        mmio_rsp_data <= rsp_stage.data;
    end

    // ======================================================================
    // Checks
    // ======================================================================

    // The host must never issue a read and a write in the same cycle
    a_one_strobe: assert property (@(posedge ccip_to_afu) disable iff (reset)
        !(mmio_rd_req && mmio_wr_req));

    // A response leaving the shim carries a known tid from the AFU
    a_rsp_tid_known: assert property (@(posedge ccip_to_afu) disable iff (reset)
        mmio_rsp_valid |-> !$isunknown(mmio_rsp_tid));

endmodule

// File: src/ccip_timing_stages.sv
// Delays any payload with its valid bit by STAGES clocks; STAGES of 0 is a plain wire
`timescale 1ns/1ns

module ccip_timing_stages
#(
    parameter type T = logic,
    parameter int STAGES = 2
)
(
    input  logic ccip_to_afu,
    input  logic reset,

    input  logic in_valid,
    input  T     in_data,

    output logic out_valid,
    output T     out_data
);

    generate
        if (STAGES == 0)
        begin : g_bypass
            // No registers requested, so the stage is transparent
            assign out_valid = in_valid;
            assign out_data = in_data;
        end
        else
        begin : g_chain
            // One valid bit and one payload register per stage
            logic valid_q [STAGES];
            T     data_q [STAGES];

            for (genvar i = 0; i < STAGES; i = i + 1)
            begin : g_stage
                if (i == 0)
                begin : g_first
                    // The first stage samples the module inputs
                    always_ff @(posedge ccip_to_afu)
                    begin
                        if (reset)
                        begin
                            valid_q[0] <= 1'b0;
                        end
                        else
                        begin
                            valid_q[0] <= in_valid;
                        end
                    end

                    // Payload shifts every cycle, whether valid or not
                    always_ff @(posedge ccip_to_afu)
                    begin
                        data_q[0] <= in_data;
                    end
                end
                else
                begin : g_next
                    // Later stages sample the stage before them
                    always_ff @(posedge ccip_to_afu)
                    begin
                        if (reset)
                        begin
                            valid_q[i] <= 1'b0;
                        end
                        else
                        begin
                            valid_q[i] <= valid_q[i-1];
                        end
                    end

                    always_ff @(posedge ccip_to_afu)
                    begin
                        data_q[i] <= data_q[i-1];
                    end
                end
            end

            // The last stage drives the outputs
            assign out_valid = valid_q[STAGES-1];
            assign out_data = data_q[STAGES-1];
        end
    endgenerate

endmodule

// File: src/platform_shim_afu_top.sv
// Shim plus AFU on one clock; the host must accept every response as it arrives
`timescale 1ns/1ns

module platform_shim_afu_top
#(
    parameter int TIMING_STAGES = 2,
    parameter afu_shim_pkg::t_mmio_data AFU_ID_LO = 64'h9c4e_11a2_5d07_4b3f,
    parameter afu_shim_pkg::t_mmio_data AFU_ID_HI = 64'h6a81_f0d3_27c5_e914
)
(
    input  logic ccip_to_afu,
    input  logic reset,

    input  logic mmio_rd_req,
    input  logic mmio_wr_req,
    input  afu_shim_pkg::t_mmio_addr mmio_addr,
    input  afu_shim_pkg::t_mmio_tid mmio_tid,
    input  afu_shim_pkg::t_mmio_data mmio_wr_data,
    input  afu_shim_pkg::t_power_state fiu_power_state,

    output logic mmio_rsp_valid,
    output afu_shim_pkg::t_mmio_tid mmio_rsp_tid,
    output afu_shim_pkg::t_mmio_data mmio_rsp_data
);

    import afu_shim_pkg::*;

    // Wires between the shim and the AFU
    logic afu_reset;
    logic rx_rd;
    logic rx_wr;
    t_mmio_addr rx_addr;
    t_mmio_tid rx_tid;
    t_mmio_data rx_data;
    t_power_state afu_power_state;
    logic tx_rsp_valid;
    t_mmio_tid tx_rsp_tid;
    t_mmio_data tx_rsp_data;

    // ======================================================================
    // Host channel shim
    // ======================================================================

    host_chan_as_ccip
    #(
        .TIMING_STAGES(TIMING_STAGES)
    )
    host_chan
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(reset),
        .mmio_rd_req(mmio_rd_req),
        .mmio_wr_req(mmio_wr_req),
        .mmio_addr(mmio_addr),
        .mmio_tid(mmio_tid),
        .mmio_wr_data(mmio_wr_data),
        .fiu_power_state(fiu_power_state),
        .mmio_rsp_valid(mmio_rsp_valid),
        .mmio_rsp_tid(mmio_rsp_tid),
        .mmio_rsp_data(mmio_rsp_data),
        .afu_reset(afu_reset),
        .rx_rd(rx_rd),
        .rx_wr(rx_wr),
        .rx_addr(rx_addr),
        .rx_tid(rx_tid),
        .rx_data(rx_data),
        .afu_power_state(afu_power_state),
        .tx_rsp_valid(tx_rsp_valid),
        .tx_rsp_tid(tx_rsp_tid),
        .tx_rsp_data(tx_rsp_data)
    );

    // ======================================================================
    // AFU
    // ======================================================================

    // The AFU runs from the registered reset, never the raw one
    afu_csr_block
    #(
        .AFU_ID_LO(AFU_ID_LO),
        .AFU_ID_HI(AFU_ID_HI)
    )
    afu
    (
        .ccip_to_afu(ccip_to_afu),
        .afu_reset(afu_reset),
        .rx_rd(rx_rd),
        .rx_wr(rx_wr),
        .rx_addr(rx_addr),
        .rx_tid(rx_tid),
        .rx_data(rx_data),
        .afu_power_state(afu_power_state),
        .tx_rsp_valid(tx_rsp_valid),
        .tx_rsp_tid(tx_rsp_tid),
        .tx_rsp_data(tx_rsp_data)
    );

endmodule

// File: tb/tb_mmio_tasks.svh
// MMIO driver tasks and CSR model; include inside tb_platform_shim after its signals exist
`ifndef TB_MMIO_TASKS_SVH
`define TB_MMIO_TASKS_SVH

// Expected responses in request order, one entry per read in flight
t_mmio_tid exp_tid_q[$];
t_mmio_data exp_data_q[$];

// Model of the AFU state that reads can observe
t_mmio_data scratch_model = '0;
logic [15:0] wr_count_model = '0;
t_power_state power_model = '0;

// Value a read of addr must return, given the model at the time of the read
function automatic t_mmio_data expected_read(input t_mmio_addr addr);
    t_mmio_data value;
    value = '0;
    if (addr == CSR_DFH)
        value = AFU_DFH_VALUE;
    else if (addr == CSR_AFU_ID_LO)
        value = AFU_ID_LO;
    else if (addr == CSR_AFU_ID_HI)
        value = AFU_ID_HI;
    else if (addr == CSR_SCRATCH)
        value = scratch_model;
    else if (addr == CSR_POWER)
        value = {62'b0, power_model};
    else if (addr == CSR_WR_COUNT)
        value = {48'b0, wr_count_model};
    return value;
endfunction

// Drives a read strobe for the next cycle and leaves it high, so calls chain back to back
task automatic issue_read(input t_mmio_addr addr);
    t_mmio_tid tid;
    tid = t_mmio_tid'($urandom);
    @(posedge ccip_to_afu);
    #1;
    mmio_rd_req = 1'b1;
    mmio_wr_req = 1'b0;
    mmio_addr = addr;
    mmio_tid = tid;
    exp_tid_q.push_back(tid);
    exp_data_q.push_back(expected_read(addr));
endtask

// A write counts wherever it lands, and only scratch keeps the data
task automatic issue_write(input t_mmio_addr addr, input t_mmio_data data);
    @(posedge ccip_to_afu);
    #1;
    mmio_rd_req = 1'b0;
    mmio_wr_req = 1'b1;
    mmio_addr = addr;
    mmio_tid = t_mmio_tid'($urandom);
    mmio_wr_data = data;
    wr_count_model = wr_count_model + 16'd1;
    if (addr == CSR_SCRATCH)
        scratch_model = data;
endtask

task automatic release_bus();
    @(posedge ccip_to_afu);
    #1;
    mmio_rd_req = 1'b0;
    mmio_wr_req = 1'b0;
endtask

// Ends the current burst and waits until every read has been answered
task automatic drain_responses();
    release_bus();
    while (exp_tid_q.size() != 0)
    begin
        @(posedge ccip_to_afu);
        #1;
    end
endtask

`endif

// File: tb/tb_platform_shim.sv
// Testbench for shim plus AFU; built for TIMING_STAGES of 2 and a host that accepts every response
`timescale 1ns/1ns

module tb_platform_shim;

    import afu_shim_pkg::*;

    localparam int TIMING_STAGES = 2;
    localparam t_mmio_data AFU_ID_LO = 64'h3b71_c0de_a5f2_0918;
    localparam t_mmio_data AFU_ID_HI = 64'hd24e_7f60_19ab_c35e;
    // Request side and response side each add one register plus the stages,
    // and the AFU adds its own response register
    localparam int RSP_LATENCY = 3 + 2 * TIMING_STAGES;
    localparam int TIMEOUT_CYCLES = 2000;

    logic ccip_to_afu;
    logic reset;
    logic mmio_rd_req;
    logic mmio_wr_req;
    t_mmio_addr mmio_addr;
    t_mmio_tid mmio_tid;
    t_mmio_data mmio_wr_data;
    t_power_state fiu_power_state;
    logic mmio_rsp_valid;
    t_mmio_tid mmio_rsp_tid;
    t_mmio_data mmio_rsp_data;

    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int errors_at_start = 0;
    int cycle_count = 0;
    t_mmio_tid head_tid;
    t_mmio_data head_data;

    `include "tb_mmio_tasks.svh"

    platform_shim_afu_top
    #(
        .TIMING_STAGES(TIMING_STAGES),
        .AFU_ID_LO(AFU_ID_LO),
        .AFU_ID_HI(AFU_ID_HI)
    )
    UUT
    (
        .ccip_to_afu(ccip_to_afu),
        .reset(reset),
        .mmio_rd_req(mmio_rd_req),
        .mmio_wr_req(mmio_wr_req),
        .mmio_addr(mmio_addr),
        .mmio_tid(mmio_tid),
        .mmio_wr_data(mmio_wr_data),
        .fiu_power_state(fiu_power_state),
        .mmio_rsp_valid(mmio_rsp_valid),
        .mmio_rsp_tid(mmio_rsp_tid),
        .mmio_rsp_data(mmio_rsp_data)
    );

    initial
    begin
        ccip_to_afu = 1'b0;
        forever #4 ccip_to_afu = ~ccip_to_afu;
    end

    // ======================================================================
    // Response checks
    // ======================================================================

    // Every response needs a read exactly RSP_LATENCY cycles earlier, and the reverse
    a_rsp_has_read: assert property (@(posedge ccip_to_afu) disable iff (reset)
        mmio_rsp_valid |-> $past(mmio_rd_req, RSP_LATENCY))
    else
    begin
        $display("A response arrived with no read %0d cycles before it", RSP_LATENCY);
        error_count++;
    end

    a_read_answered: assert property (@(posedge ccip_to_afu) disable iff (reset)
        $past(mmio_rd_req, RSP_LATENCY) |-> mmio_rsp_valid)
    else
    begin
        $display("A read got no response %0d cycles after it was issued", RSP_LATENCY);
        error_count++;
    end

    // The output register clears in the cycle after reset is seen
    a_reset_quiet: assert property (@(posedge ccip_to_afu) reset |=> !mmio_rsp_valid)
    else
    begin
        $display("mmio_rsp_valid was high while reset was held");
        error_count++;
    end

    // Response contents are compared with the head of the expected queue
    always @(posedge ccip_to_afu)
    begin
        if (!reset && mmio_rsp_valid)
        begin
            if (exp_tid_q.size() == 0)
            begin
                $display("A response arrived while no read was outstanding");
                error_count++;
            end
            else
            begin
                head_tid = exp_tid_q.pop_front();
                head_data = exp_data_q.pop_front();
                check_count++;
                a_tid_match: assert (mmio_rsp_tid == head_tid)
                else
                begin
                    $display("FAILED mmio_rsp_tid expected 0x%h got 0x%h", head_tid, mmio_rsp_tid);
                    error_count++;
                end
                a_data_match: assert (mmio_rsp_data == head_data)
                else
                begin
                    $display("FAILED mmio_rsp_data expected 0x%h got 0x%h",
                             head_data, mmio_rsp_data);
                    error_count++;
                end
            end
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    initial
    begin
        int n_writes;
        void'($urandom(40806));
        reset = 1'b1;
        mmio_rd_req = 1'b0;
        mmio_wr_req = 1'b0;
        mmio_addr = '0;
        mmio_tid = '0;
        mmio_wr_data = '0;
        fiu_power_state = '0;
        repeat (5) @(posedge ccip_to_afu);
        #1;
        reset = 1'b0;

        // Idle bus first, so any stray response trips the latency check
        repeat (12) @(posedge ccip_to_afu);
        issue_read(CSR_SCRATCH);
        issue_read(CSR_WR_COUNT);
        drain_responses();
        report_test("reset defaults");

        issue_read(CSR_DFH);
        drain_responses();
        issue_read(CSR_AFU_ID_LO);
        drain_responses();
        issue_read(CSR_AFU_ID_HI);
        drain_responses();
        report_test("header and id");

        issue_write(CSR_SCRATCH, {$urandom, $urandom});
        issue_read(CSR_SCRATCH);
        drain_responses();
        n_writes = $urandom_range(9, 3);
        for (int i = 0; i < n_writes; i++)
        begin
            issue_write(16'h000C + t_mmio_addr'(2 * i), {$urandom, $urandom});
        end
        issue_write(CSR_SCRATCH, {$urandom, $urandom});
        issue_read(CSR_SCRATCH);
        issue_read(CSR_WR_COUNT);
        drain_responses();
        report_test("scratch and write count");

        // Back to back reads, including unmapped words above the CSR map
        issue_read(CSR_DFH);
        issue_read(CSR_SCRATCH);
        issue_read(16'h0010 + t_mmio_addr'($urandom_range(255, 0)));
        issue_read(CSR_WR_COUNT);
        issue_read(CSR_AFU_ID_HI);
        issue_read(16'h0003);
        issue_read(CSR_POWER);
        drain_responses();
        report_test("back to back reads");

        for (int i = 0; i < 2; i++)
        begin
            power_model = power_model ^ t_power_state'($urandom_range(3, 1));
            fiu_power_state = power_model;
            repeat (5) @(posedge ccip_to_afu);
            issue_read(CSR_POWER);
            drain_responses();
        end
        report_test("power state");

        // The readback makes sure the nonzero value has landed before reset
        issue_write(CSR_SCRATCH, {$urandom, $urandom} | 64'h1);
        issue_read(CSR_SCRATCH);
        drain_responses();

        // A burst one longer than the latency leaves a response in every
        // pipeline stage, including the output register, when reset hits
        for (int i = 0; i < RSP_LATENCY + 1; i++)
        begin
            issue_read(CSR_DFH);
        end
        @(posedge ccip_to_afu);
        #1;
        mmio_rd_req = 1'b0;
        reset = 1'b1;
        repeat (RSP_LATENCY + 1) @(posedge ccip_to_afu);
        #1;
        reset = 1'b0;
        // Reads cut off by reset never get an answer
        exp_tid_q.delete();
        exp_data_q.delete();
        scratch_model = '0;
        wr_count_model = '0;
        issue_read(CSR_SCRATCH);
        issue_read(CSR_WR_COUNT);
        drain_responses();
        report_test("mid-run reset");

        $display("tests %0d, response checks %0d, errors %0d",
                 test_count, check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // Watchdog, well above the cycles the sequence needs
    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge ccip_to_afu);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
